/* source/engine_defs.svh */
`ifndef ENGINE_DEFS_SVH
`define ENGINE_DEFS_SVH

// Word and address sizes of the data memory
`define ENGINE_ADDR_WIDTH 6
`define ENGINE_DATA_WIDTH 16
`define ENGINE_MEM_DEPTH 64

// Each wait counter runs through all of its values to let the memory settle
`define ENGINE_WAIT_BITS 3

// Number of operation steps applied to the working word
`define ENGINE_PROCESS_DONE 4

`endif

/* source/engine_command_pkg.sv */
`default_nettype none

`include "engine_defs.svh"

package engine_command_pkg;

	// Operation applied to the addressed word on each process step
	typedef enum logic [1:0] {
		OP_ADD        = 2'd0,
		OP_SUB        = 2'd1,
		// Xor with the operand, then rotate left by one
		OP_XOR_ROTATE = 2'd2,
		// Byte swap, operand unused
		OP_SWAP       = 2'd3
	} command_op_t;

	// One command as carried by the start strobe
	typedef struct packed {
		logic [`ENGINE_ADDR_WIDTH-1:0] address;
		command_op_t                   op;
		logic [`ENGINE_DATA_WIDTH-1:0] operand;
	} command_t;

endpackage

`default_nettype wire

/* source/engine_control_pkg.sv */
`default_nettype none

package engine_control_pkg;

	// Sequencer states, in the order they are visited
	typedef enum logic [2:0] {
		STATE_IDLE    = 3'd0,
		STATE_LOAD    = 3'd1,
		STATE_SETTLE  = 3'd2,
		STATE_PROCESS = 3'd3,
		STATE_WRITE   = 3'd4
	} control_state_t;

	// Status seen by the host
	typedef struct packed {
		logic done;
		logic busy;
	} engine_status_t;

endpackage

`default_nettype wire

/* source/command_intake.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module command_intake (
	input  wire                            clock,
	input  wire                            resetn,
	input  wire                            start,
	input  engine_command_pkg::command_t   command,
	input  wire                            done,
	output logic                           load_memory,
	output engine_command_pkg::command_t   held_command
);

	logic accept;

	// A strobe is taken only while the engine is idle, anything else is dropped
	assign accept = start & done;

	// Controller leaves idle on the same edge that captures the command
	assign load_memory = accept;

	// Held until the next accepted strobe so address and op stay put
	always_ff @(posedge clock) begin
		if (!resetn) begin
			held_command <= '0;
		end else if (accept) begin
			held_command <= command;
		end
	end

endmodule

`default_nettype wire

/* source/memory_control.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module memory_control (
	input  wire       clock,
	input  wire       resetn,
	input  wire       load_memory,
	input  wire [2:0] process,
	output logic      load_registers,
	output logic      write_enable,
	output logic      done
);

	localparam logic [`ENGINE_WAIT_BITS-1:0] WAIT_LAST = '1;
	localparam logic [2:0] PROCESS_LAST = 3'(`ENGINE_PROCESS_DONE);

	engine_control_pkg::control_state_t state;
	engine_control_pkg::control_state_t next_state;

	// Wait counters give the memory time to settle
	logic [`ENGINE_WAIT_BITS-1:0] waited_1;
	logic [`ENGINE_WAIT_BITS-1:0] waited_2;
	logic [`ENGINE_WAIT_BITS-1:0] waited_3;
	logic count_1;
	logic count_2;
	logic count_3;

	// Each counter runs only in its own state and wraps to zero as it exits
	always_ff @(posedge clock) begin
		if (!resetn) begin
			waited_1 <= '0;
			waited_2 <= '0;
			waited_3 <= '0;
		end else begin
			if (count_1) begin
				waited_1 <= waited_1 + 1'b1;
			end
			if (count_2) begin
				waited_2 <= waited_2 + 1'b1;
			end
			if (count_3) begin
				waited_3 <= waited_3 + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			engine_control_pkg::STATE_IDLE: begin
				if (load_memory) begin
					next_state = engine_control_pkg::STATE_LOAD;
				end
			end
			engine_control_pkg::STATE_LOAD: begin
				if (waited_1 == WAIT_LAST) begin
					next_state = engine_control_pkg::STATE_SETTLE;
				end
			end
			engine_control_pkg::STATE_SETTLE: begin
				if (waited_2 == WAIT_LAST) begin
					next_state = engine_control_pkg::STATE_PROCESS;
				end
			end
			engine_control_pkg::STATE_PROCESS: begin
				// Processor reports its step count
				if (process == PROCESS_LAST) begin
					next_state = engine_control_pkg::STATE_WRITE;
				end
			end
			engine_control_pkg::STATE_WRITE: begin
				if (waited_3 == WAIT_LAST) begin
					next_state = engine_control_pkg::STATE_IDLE;
				end
			end
			default: begin
				next_state = engine_control_pkg::STATE_IDLE;
			end
		endcase
	end

	// Outputs decoded from the state alone
	always_comb begin
		count_1 = 1'b0;
		count_2 = 1'b0;
		count_3 = 1'b0;
		load_registers = 1'b0;
		write_enable = 1'b0;
		done = 1'b0;
		case (state)
			engine_control_pkg::STATE_IDLE: begin
				done = 1'b1;
			end
			engine_control_pkg::STATE_LOAD: begin
				count_1 = 1'b1;
			end
			engine_control_pkg::STATE_SETTLE: begin
				count_2 = 1'b1;
				load_registers = 1'b1;
			end
			engine_control_pkg::STATE_WRITE: begin
				count_3 = 1'b1;
				write_enable = 1'b1;
			end
			default: begin
				done = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!resetn) begin
			state <= engine_control_pkg::STATE_IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module data_memory (
	input  wire                          clock,
	input  wire                          resetn,
	input  wire                          done,
	input  wire                          host_write,
	input  wire [`ENGINE_ADDR_WIDTH-1:0] host_addr,
	input  wire [`ENGINE_DATA_WIDTH-1:0] host_wdata,
	output logic [`ENGINE_DATA_WIDTH-1:0] host_rdata,
	input  wire [`ENGINE_ADDR_WIDTH-1:0] engine_addr,
	input  wire                          write_enable,
	input  wire [`ENGINE_DATA_WIDTH-1:0] write_data,
	output logic [`ENGINE_DATA_WIDTH-1:0] read_data
);

	logic [`ENGINE_DATA_WIDTH-1:0] mem [`ENGINE_MEM_DEPTH];
	logic [`ENGINE_DATA_WIDTH-1:0] rdata_q;
	logic [`ENGINE_ADDR_WIDTH-1:0] addr;
	logic [`ENGINE_DATA_WIDTH-1:0] wdata;
	logic                          wen;

	// Host owns the port while idle, the engine while busy
	assign addr  = done ? host_addr : engine_addr;
	assign wdata = done ? host_wdata : write_data;
	assign wen   = done ? host_write : write_enable;

	always_ff @(posedge clock) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
	end

	// One registered read serves both sides
	always_ff @(posedge clock) begin
		if (!resetn) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= mem[addr];
		end
	end

	assign host_rdata = rdata_q;
	assign read_data  = rdata_q;

endmodule

`default_nettype wire

/* source/word_processor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module word_processor (
	input  wire                             clock,
	input  wire                             resetn,
	input  wire                             load_registers,
	input  wire [`ENGINE_DATA_WIDTH-1:0]    read_data,
	input  engine_command_pkg::command_op_t op,
	input  wire [`ENGINE_DATA_WIDTH-1:0]    operand,
	input  wire                             write_enable,
	output logic [2:0]                      process,
	output logic [`ENGINE_DATA_WIDTH-1:0]   result
);

	localparam int W = `ENGINE_DATA_WIDTH;
	localparam logic [2:0] PROCESS_LAST = 3'(`ENGINE_PROCESS_DONE);

	logic [W-1:0] work;
	logic [W-1:0] mixed;
	logic [W-1:0] stepped;
	logic         running;
	logic         step;

	assign mixed = work ^ operand;

	// One application of the command rule
	always_comb begin
		case (op)
			engine_command_pkg::OP_ADD:        stepped = work + operand;
			engine_command_pkg::OP_SUB:        stepped = work - operand;
			engine_command_pkg::OP_XOR_ROTATE: stepped = {mixed[W-2:0], mixed[W-1]};
			engine_command_pkg::OP_SWAP:       stepped = {work[W/2-1:0], work[W-1:W/2]};
			default:                           stepped = work;
		endcase
	end

	// Steps only between the capture and the write-back
	assign step = running & ~load_registers & (process != PROCESS_LAST);

	always_ff @(posedge clock) begin
		if (!resetn) begin
			running <= 1'b0;
			process <= '0;
		end else if (load_registers) begin
			running <= 1'b1;
			process <= '0;
		end else if (write_enable) begin
			running <= 1'b0;
			process <= '0;
		end else if (step) begin
			process <= process + 1'b1;
		end
	end

	// Working word
	always_ff @(posedge clock) begin
		if (load_registers) begin
			work <= read_data;
		end else if (step) begin
			work <= stepped;
		end
	end

	assign result = work;

endmodule

`default_nettype wire

/* source/block_engine_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module block_engine_top (
	input  wire                                 clock,
	input  wire                                 resetn,
	input  wire                                 start,
	input  engine_command_pkg::command_t        command,
	input  wire                                 host_write,
	input  wire [`ENGINE_ADDR_WIDTH-1:0]        host_addr,
	input  wire [`ENGINE_DATA_WIDTH-1:0]        host_wdata,
	output logic [`ENGINE_DATA_WIDTH-1:0]       host_rdata,
	output engine_control_pkg::engine_status_t  status
);

	engine_command_pkg::command_t  held_command;
	logic                          load_memory;
	logic                          load_registers;
	logic                          write_enable;
	logic                          done;
	logic [2:0]                    process;
	logic [`ENGINE_DATA_WIDTH-1:0] result;
	logic [`ENGINE_DATA_WIDTH-1:0] read_data;

	command_intake u_intake (
		.clock        (clock),
		.resetn       (resetn),
		.start        (start),
		.command      (command),
		.done         (done),
		.load_memory  (load_memory),
		.held_command (held_command)
	);

	memory_control u_control (
		.clock          (clock),
		.resetn         (resetn),
		.load_memory    (load_memory),
		.process        (process),
		.load_registers (load_registers),
		.write_enable   (write_enable),
		.done           (done)
	);

	// Engine side addressed by the held command for the whole sequence
	data_memory u_memory (
		.clock        (clock),
		.resetn       (resetn),
		.done         (done),
		.host_write   (host_write),
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.host_rdata   (host_rdata),
		.engine_addr  (held_command.address),
		.write_enable (write_enable),
		.write_data   (result),
		.read_data    (read_data)
	);

	word_processor u_processor (
		.clock          (clock),
		.resetn         (resetn),
		.load_registers (load_registers),
		.read_data      (read_data),
		.op             (held_command.op),
		.operand        (held_command.operand),
		.write_enable   (write_enable),
		.process        (process),
		.result         (result)
	);

	assign status.done = done;
	assign status.busy = ~done;

endmodule

`default_nettype wire

/* sim/block_engine_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "engine_defs.svh"

module block_engine_tb;

	localparam int DEPTH = `ENGINE_MEM_DEPTH;
	localparam int W = `ENGINE_DATA_WIDTH;
	localparam int RANDOM_COMMANDS = 60;
	// A command applies its operation four times
	localparam int STEPS_PER_COMMAND = 4;
	// Four single-op commands, the random run and the two busy tests
	localparam int NUM_COMMANDS = 4 + RANDOM_COMMANDS + 2;
	// Every state held for a full wait count
	localparam int COMMAND_CYCLES =
		(int'(engine_control_pkg::STATE_WRITE) + 1) * (1 << `ENGINE_WAIT_BITS);
	localparam int HOST_CYCLES = 8;
	localparam int PRELOAD_CYCLES = 2 * DEPTH + 8;
	localparam int CYCLE_LIMIT =
		PRELOAD_CYCLES + NUM_COMMANDS * (COMMAND_CYCLES + HOST_CYCLES) + 100;
	localparam int DONE_WAIT_LIMIT = 2 * COMMAND_CYCLES;

	typedef logic [`ENGINE_ADDR_WIDTH-1:0] addr_t;
	typedef logic [W-1:0] word_t;

	logic clock = 1'b0;
	logic resetn;
	logic start;
	engine_command_pkg::command_t command;
	logic host_write;
	addr_t host_addr;
	word_t host_wdata;
	word_t host_rdata;
	engine_control_pkg::engine_status_t status;

	// Expected memory contents
	word_t model [DEPTH];
	logic [31:0] lfsr_state;
	int cycle_count = 0;
	int check_count;
	int error_count;

	always #20 clock = ~clock;

	block_engine_top UUT (
		.clock      (clock),
		.resetn     (resetn),
		.start      (start),
		.command    (command),
		.host_write (host_write),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.status     (status)
	);

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Result: FAILED");
			$finish;
		end
	end

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] value);
		logic [31:0] next;
		next = value >> 1;
		if (value[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic word_t apply_rule(
		input word_t value,
		input engine_command_pkg::command_op_t op,
		input word_t operand
	);
		word_t outcome;
		case (op)
			engine_command_pkg::OP_ADD: begin
				outcome = value + operand;
			end
			engine_command_pkg::OP_SUB: begin
				outcome = value - operand;
			end
			engine_command_pkg::OP_XOR_ROTATE: begin
				outcome = value ^ operand;
				outcome = (outcome << 1) | (outcome >> (W - 1));
			end
			engine_command_pkg::OP_SWAP: begin
				outcome = (value << (W / 2)) | (value >> (W / 2));
			end
			default: begin
				outcome = value;
			end
		endcase
		return outcome;
	endfunction

	function automatic word_t apply_command(
		input word_t value,
		input engine_command_pkg::command_t cmd
	);
		word_t outcome;
		outcome = value;
		for (int i = 0; i < STEPS_PER_COMMAND; i++) begin
			outcome = apply_rule(outcome, cmd.op, cmd.operand);
		end
		return outcome;
	endfunction

	function automatic engine_command_pkg::command_t random_command();
		engine_command_pkg::command_t cmd;
		cmd.address = addr_t'(take_bits(`ENGINE_ADDR_WIDTH));
		cmd.op = engine_command_pkg::command_op_t'(2'(take_bits(2)));
		cmd.operand = word_t'(take_bits(W));
		return cmd;
	endfunction

	task automatic write_host_word(input addr_t addr, input word_t data);
		host_write = 1'b1;
		host_addr = addr;
		host_wdata = data;
		@(negedge clock);
		host_write = 1'b0;
	endtask

	// Registered read data is valid one cycle after the address
	task automatic read_host_word(input addr_t addr, output word_t data);
		host_addr = addr;
		@(negedge clock);
		data = host_rdata;
	endtask

	task automatic check_stored(input addr_t addr);
		word_t value;
		read_host_word(addr, value);
		check_count++;
		if (value !== model[addr]) begin
			error_count++;
			$display("[ERROR] %0t: word at %0d is %h, expected %h",
				$time, addr, value, model[addr]);
		end
	endtask

	task automatic check_busy(input logic expected);
		check_count++;
		if (status.busy !== expected || status.done !== ~expected) begin
			error_count++;
			$display("[ERROR] %0t: status done %b busy %b, expected busy %b",
				$time, status.done, status.busy, expected);
		end
	endtask

	task automatic issue_start(input engine_command_pkg::command_t cmd);
		command = cmd;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_for_done();
		int waited;
		waited = 0;
		while (!status.done && waited < DONE_WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		check_count++;
		if (!status.done) begin
			error_count++;
			$display("Command did not finish: done stayed low for %0d cycles at time %0t",
				waited, $time);
		end
	endtask

	task automatic run_command(input engine_command_pkg::command_t cmd);
		issue_start(cmd);
		check_busy(1'b1);
		wait_for_done();
		model[cmd.address] = apply_command(model[cmd.address], cmd);
	endtask

	task automatic report_test(input int number, input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("Test %0d %s: ok", number, name);
		end else begin
			$display("Test %0d %s: %0d errors", number, name, error_count - errors_before);
		end
	endtask

	initial begin
		engine_command_pkg::command_t cmd;
		engine_command_pkg::command_t second;
		addr_t addr;
		word_t data;
		int errors_before;

		resetn = 1'b0;
		start = 1'b0;
		command = '0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		lfsr_state = 32'he01a;
		check_count = 0;
		error_count = 0;

		repeat (2) @(negedge clock);
		resetn = 1'b1;

		// Status after reset, then fill the whole memory and read it back
		errors_before = error_count;
		check_busy(1'b0);
		for (int i = 0; i < DEPTH; i++) begin
			model[addr_t'(i)] = word_t'(take_bits(W));
			write_host_word(addr_t'(i), model[addr_t'(i)]);
		end
		for (int i = 0; i < DEPTH; i++) begin
			check_stored(addr_t'(i));
		end
		report_test(1, "reset and preload", errors_before);

		// One command per operation with its neighbours left untouched
		errors_before = error_count;
		for (int i = 0; i < 4; i++) begin
			cmd = random_command();
			cmd.op = engine_command_pkg::command_op_t'(2'(i));
			run_command(cmd);
			check_stored(cmd.address);
			check_stored(addr_t'(cmd.address - 1));
			check_stored(addr_t'(cmd.address + 1));
		end
		report_test(2, "each operation", errors_before);

		errors_before = error_count;
		for (int i = 0; i < RANDOM_COMMANDS; i++) begin
			cmd = random_command();
			run_command(cmd);
			check_stored(cmd.address);
		end
		report_test(3, "random commands", errors_before);

		// Second strobe while busy is dropped
		errors_before = error_count;
		cmd = random_command();
		second = random_command();
		if (second.address == cmd.address) begin
			second.address = addr_t'(cmd.address + 1);
		end
		issue_start(cmd);
		check_busy(1'b1);
		repeat (3) @(negedge clock);
		issue_start(second);
		wait_for_done();
		model[cmd.address] = apply_command(model[cmd.address], cmd);
		check_stored(cmd.address);
		check_stored(second.address);
		report_test(4, "start while busy", errors_before);

		// Host write while busy is ignored
		errors_before = error_count;
		cmd = random_command();
		addr = addr_t'(take_bits(`ENGINE_ADDR_WIDTH));
		data = word_t'(take_bits(W));
		if (data == model[addr]) begin
			data = ~data;
		end
		issue_start(cmd);
		check_busy(1'b1);
		repeat (5) @(negedge clock);
		write_host_word(addr, data);
		wait_for_done();
		model[cmd.address] = apply_command(model[cmd.address], cmd);
		check_stored(addr);
		check_stored(cmd.address);
		report_test(5, "host write while busy", errors_before);

		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/engine_command_pkg.sv
source/engine_control_pkg.sv
source/command_intake.sv
source/memory_control.sv
source/data_memory.sv
source/word_processor.sv
source/block_engine_top.sv
sim/block_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f src.f \
	--top-module block_engine_tb -o block_engine_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/block_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
